/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  ////////////////////////////////////////
  // Word and field types
  ////////////////////////////////////////

  // Full RV32 instruction word
  typedef logic [31:0] instr32_t;
  // Compressed instruction word from fetch
  typedef logic [15:0] cinstr_t;
  // Architectural register index
  typedef logic [4:0] reg_idx_t;
  // I-type and S-type immediate
  typedef logic signed [11:0] imm12_t;

  ////////////////////////////////////////
  // Encoding constants
  ////////////////////////////////////////

  // Major opcodes used by the sequencer
  localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE = 7'b0100011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
  localparam logic [6:0] OPCODE_JALR  = 7'b1100111;

  // ABI register numbers
  localparam reg_idx_t REG_ZERO = 5'd0;
  localparam reg_idx_t REG_RA   = 5'd1;
  localparam reg_idx_t REG_SP   = 5'd2;
  localparam reg_idx_t REG_A0   = 5'd10;
  localparam reg_idx_t REG_A1   = 5'd11;

  // Word access and addi
  localparam logic [2:0] FUNCT3_W    = 3'b010;
  localparam logic [2:0] FUNCT3_ADDI = 3'b000;

endpackage

`default_nettype wire

/* zcmp_seq_pkg.sv */
`default_nettype none

package zcmp_seq_pkg;

  // rlist field of push/pop
  typedef logic [3:0] rlist_t;
  // Number of saved s-registers, 0 to 12
  typedef logic [3:0] sreg_cnt_t;
  // Words emitted so far in a sequence
  typedef logic [4:0] step_t;

  // Decoded kind of compressed word
  typedef enum logic [2:0] {
    SEQ_NONE,
    SEQ_PUSH,
    SEQ_POP,
    SEQ_POPRET,
    SEQ_POPRETZ,
    SEQ_MVSA01,
    SEQ_MVA01S
  } seq_instr_e;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    S_IDLE,
    S_SREG,
    S_RA,
    S_SP,
    S_A0,
    S_RET,
    S_DMOVE
  } seq_state_e;

  ////////////////////////////////////////
  // rlist helpers
  ////////////////////////////////////////

  // rlist 4 is ra only, 15 jumps straight to s0-s11
  function automatic sreg_cnt_t sreg_count(rlist_t rlist);
    sreg_cnt_t cnt;
    if (rlist == 4'd15) begin
      cnt = 4'd12;
    end else if (rlist < 4'd4) begin
      cnt = 4'd0;
    end else begin
      cnt = rlist - 4'd4;
    end
    return cnt;
  endfunction

  // Bytes for s-registers plus ra, 16 byte aligned
  function automatic rv_isa_pkg::imm12_t stack_base(rlist_t rlist);
    logic [11:0] bytes;
    bytes = {6'd0, sreg_count(rlist), 2'b00} + 12'd4;
    return (bytes + 12'd15) & 12'hff0;
  endfunction

  // s0/s1 live at x8/x9, the rest at x18 upward
  function automatic rv_isa_pkg::reg_idx_t sreg_to_regnum(sreg_cnt_t n);
    rv_isa_pkg::reg_idx_t idx;
    if (n == 4'd0) begin
      idx = 5'd8;
    end else if (n == 4'd1) begin
      idx = 5'd9;
    end else begin
      idx = 5'd16 + {1'b0, n};
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

/* zcmp_decoder.sv */
`default_nettype none

module zcmp_decoder #(
  parameter bit EMBEDDED = 1'b0
) (
  input  rv_isa_pkg::cinstr_t      instr_i,
  input  logic                     valid_i,
  input  logic                     halt_i,
  input  logic                     kill_i,
  output zcmp_seq_pkg::seq_instr_e seq_instr_o,
  output logic                     valid_o,
  output logic                     seq_pushpop_o
);
  import zcmp_seq_pkg::*;

  rlist_t     rlist;
  logic [2:0] r1s;
  logic [2:0] r2s;
  logic       rlist_legal;
  logic       dmove_legal;

  assign rlist = instr_i[7:4];
  assign r1s   = instr_i[9:7];
  assign r2s   = instr_i[4:2];

  ////////////////////////////////////////
  // Legality
  ////////////////////////////////////////

  // rlist 0-3 reserved and RV32E has no s2 and above
  assign rlist_legal = EMBEDDED ? ((rlist > 4'd3) && (rlist < 4'd7)) : (rlist > 4'd3);

  // Double move needs two distinct s-registers
  assign dmove_legal = (r1s != r2s) && (!EMBEDDED || ((r1s < 3'd2) && (r2s < 3'd2)));

  ////////////////////////////////////////
  // Classification
  ////////////////////////////////////////

  always_comb begin
    seq_instr_o = SEQ_NONE;
    // All Zcmp words sit in C2 with funct3 101
    if ((instr_i[1:0] == 2'b10) && (instr_i[15:13] == 3'b101)) begin
      case (instr_i[12:10])
        3'b011: begin
          if (dmove_legal) begin
            if (instr_i[6:5] == 2'b11) begin
              seq_instr_o = SEQ_MVA01S;
            end else if (instr_i[6:5] == 2'b01) begin
              seq_instr_o = SEQ_MVSA01;
            end
          end
        end
        3'b110: begin
          // cm.push / cm.pop
          if (rlist_legal && (instr_i[9:8] == 2'b00)) begin
            seq_instr_o = SEQ_PUSH;
          end else if (rlist_legal && (instr_i[9:8] == 2'b10)) begin
            seq_instr_o = SEQ_POP;
          end
        end
        3'b111: begin
          // cm.popretz / cm.popret
          if (rlist_legal && (instr_i[9:8] == 2'b00)) begin
            seq_instr_o = SEQ_POPRETZ;
          end else if (rlist_legal && (instr_i[9:8] == 2'b10)) begin
            seq_instr_o = SEQ_POPRET;
          end
        end
        default: begin
          seq_instr_o = SEQ_NONE;
        end
      endcase
    end
  end

  assign seq_pushpop_o = seq_instr_o inside {SEQ_PUSH, SEQ_POP, SEQ_POPRET, SEQ_POPRETZ};

  // Halt and kill both mask the output
  assign valid_o = (seq_instr_o != SEQ_NONE) && valid_i && !halt_i && !kill_i;

endmodule

`default_nettype wire

/* zcmp_stack_calc.sv */
`default_nettype none

module zcmp_stack_calc (
  input  rv_isa_pkg::cinstr_t      instr_i,
  input  zcmp_seq_pkg::seq_instr_e seq_instr_i,
  input  zcmp_seq_pkg::step_t      step_i,
  output zcmp_seq_pkg::sreg_cnt_t  sreg_total_o,
  output rv_isa_pkg::imm12_t       total_adj_o,
  output rv_isa_pkg::imm12_t       cur_offset_o,
  output rv_isa_pkg::reg_idx_t     cur_sreg_o
);
  import rv_isa_pkg::*;
  import zcmp_seq_pkg::*;

  rlist_t     rlist;
  logic [1:0] spimm;
  imm12_t     extra_adj;
  imm12_t     step_bytes;
  sreg_cnt_t  sreg_num;

  assign rlist = instr_i[7:4];
  assign spimm = instr_i[3:2];

  assign sreg_total_o = sreg_count(rlist);

  // spimm adds whole 16 byte blocks
  assign extra_adj   = imm12_t'({spimm, 4'b0000});
  assign total_adj_o = stack_base(rlist) + extra_adj;

  // Byte distance of the current slot below the frame top
  assign step_bytes = imm12_t'({step_i + 5'd1, 2'b00});

  always_comb begin
    case (seq_instr_i)
      // Push stores below the old sp
      SEQ_PUSH: cur_offset_o = -step_bytes;
      // Pops rewind by the full frame first
      SEQ_POP, SEQ_POPRET, SEQ_POPRETZ: cur_offset_o = total_adj_o - step_bytes;
      default: cur_offset_o = '0;
    endcase
  end

  // Highest s-register first
  assign sreg_num   = sreg_cnt_t'(step_t'(sreg_total_o) - step_i - 5'd1);
  assign cur_sreg_o = sreg_to_regnum(sreg_num);

endmodule

`default_nettype wire

/* zcmp_seq_fsm.sv */
`default_nettype none

module zcmp_seq_fsm (
  input  logic                     clk,
  input  logic                     rst_n,
  input  rv_isa_pkg::cinstr_t      instr_i,
  input  zcmp_seq_pkg::seq_instr_e seq_instr_i,
  input  logic                     valid_i,
  input  logic                     ready_i,
  input  logic                     halt_i,
  input  logic                     kill_i,
  input  zcmp_seq_pkg::sreg_cnt_t  sreg_total_i,
  input  rv_isa_pkg::imm12_t       total_adj_i,
  input  rv_isa_pkg::imm12_t       cur_offset_i,
  input  rv_isa_pkg::reg_idx_t     cur_sreg_i,
  output zcmp_seq_pkg::step_t      step_o,
  output rv_isa_pkg::instr32_t     instr_o,
  output logic                     ready_o,
  output logic                     seq_first_o,
  output logic                     seq_last_o
);
  import rv_isa_pkg::*;
  import zcmp_seq_pkg::*;

  seq_state_e state_q;
  seq_state_e state_n;
  step_t      step_q;
  logic       is_load;
  logic       is_store;
  logic       stack_op;
  logic       is_mv_a2s;
  reg_idx_t   dm_r1;
  reg_idx_t   dm_r2;

  // lw rd, off(sp) or sw rs2, off(sp)
  function automatic instr32_t mem_word(logic load, reg_idx_t r, imm12_t off);
    instr32_t w;
    if (load) begin
      w = {off, REG_SP, FUNCT3_W, r, OPCODE_LOAD};
    end else begin
      w = {off[11:5], r, REG_SP, FUNCT3_W, off[4:0], OPCODE_STORE};
    end
    return w;
  endfunction

  function automatic instr32_t addi_word(reg_idx_t rd, reg_idx_t rs1, imm12_t imm);
    return {imm, rs1, FUNCT3_ADDI, rd, OPCODE_OPIMM};
  endfunction

  assign is_store  = (seq_instr_i == SEQ_PUSH);
  assign is_load   = seq_instr_i inside {SEQ_POP, SEQ_POPRET, SEQ_POPRETZ};
  assign stack_op  = is_store || is_load;
  assign is_mv_a2s = (seq_instr_i == SEQ_MVSA01);

  // Double-move s-register fields
  assign dm_r1 = sreg_to_regnum(sreg_cnt_t'(instr_i[9:7]));
  assign dm_r2 = sreg_to_regnum(sreg_cnt_t'(instr_i[4:2]));

  ////////////////////////////////////////
  // State and step counter
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      step_q  <= '0;
    end else begin
      // Advance only on an accepted word
      if (valid_i && ready_i) begin
        step_q  <= seq_last_o ? '0 : step_q + 5'd1;
        state_q <= state_n;
      end
      // Kill wins over halt while halt keeps the sequence
      if ((!valid_i && !halt_i) || kill_i) begin
        step_q  <= '0;
        state_q <= S_IDLE;
      end
    end
  end

  assign step_o = step_q;

  ////////////////////////////////////////
  // Word assembly and next state
  ////////////////////////////////////////

  always_comb begin
    // Outside a sequence the compressed word passes zero extended
    instr_o    = instr32_t'(instr_i);
    state_n    = state_q;
    seq_last_o = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (stack_op && (sreg_total_i == 4'd0)) begin
          // With no s-registers ra goes first
          instr_o = mem_word(is_load, REG_RA, cur_offset_i);
          state_n = S_SP;
        end else if (stack_op) begin
          instr_o = mem_word(is_load, cur_sreg_i, cur_offset_i);
          state_n = (sreg_total_i == 4'd1) ? S_RA : S_SREG;
        end else if (is_mv_a2s) begin
          instr_o = addi_word(dm_r1, REG_A0, '0);
          state_n = S_DMOVE;
        end else if (seq_instr_i == SEQ_MVA01S) begin
          instr_o = addi_word(REG_A0, dm_r1, '0);
          state_n = S_DMOVE;
        end
      end
      S_SREG: begin
        instr_o = mem_word(is_load, cur_sreg_i, cur_offset_i);
        // Last s-register leaves for ra
        if (step_q + 5'd1 == step_t'(sreg_total_i)) begin
          state_n = S_RA;
        end
      end
      S_RA: begin
        instr_o = mem_word(is_load, REG_RA, cur_offset_i);
        state_n = S_SP;
      end
      S_SP: begin
        // Pops release the frame and push allocates it
        instr_o = addi_word(REG_SP, REG_SP, is_load ? total_adj_i : -total_adj_i);
        if (seq_instr_i == SEQ_POPRETZ) begin
          state_n = S_A0;
        end else if (seq_instr_i == SEQ_POPRET) begin
          state_n = S_RET;
        end else begin
          state_n    = S_IDLE;
          seq_last_o = 1'b1;
        end
      end
      S_A0: begin
        instr_o = addi_word(REG_A0, REG_ZERO, '0);
        state_n = S_RET;
      end
      S_RET: begin
        // jalr x0, 0(ra)
        instr_o    = {12'h000, REG_RA, 3'b000, REG_ZERO, OPCODE_JALR};
        state_n    = S_IDLE;
        seq_last_o = 1'b1;
      end
      S_DMOVE: begin
        instr_o    = is_mv_a2s ? addi_word(dm_r2, REG_A1, '0) : addi_word(REG_A1, dm_r2, '0);
        state_n    = S_IDLE;
        seq_last_o = 1'b1;
      end
      default: begin
        state_n = S_IDLE;
      end
    endcase
  end

  assign seq_first_o = (state_q == S_IDLE);

  // Fetch may drop the word after the last one, or whenever idle or killed
  assign ready_o = (seq_last_o && ready_i && !halt_i) || (!valid_i && !halt_i) || kill_i;

  // A sequence always starts from a cleared counter
  first_step_a: assert property (@(posedge clk) disable iff (!rst_n)
    seq_first_o |-> (step_q == '0));

  // Counter stays inside the s-register slots
  sreg_step_a: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_i && (state_q == S_SREG)) |-> (step_q < step_t'(sreg_total_i)));

  // ra follows right after the last s-register
  ra_step_a: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_i && (state_q == S_RA)) |-> (step_q == step_t'(sreg_total_i)));

endmodule

`default_nettype wire

/* zcmp_sequencer.sv */
`default_nettype none

module zcmp_sequencer #(
  parameter bit EMBEDDED = 1'b0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_isa_pkg::cinstr_t  instr_i,
  input  logic                 valid_i,
  input  logic                 ready_i,
  input  logic                 halt_i,
  input  logic                 kill_i,
  output rv_isa_pkg::instr32_t instr_o,
  output logic                 valid_o,
  output logic                 ready_o,
  output logic                 seq_first_o,
  output logic                 seq_last_o,
  output logic                 seq_pushpop_o
);
  import rv_isa_pkg::*;
  import zcmp_seq_pkg::*;

  // Decoded kind, shared by calculator and FSM
  seq_instr_e seq_instr;
  // Stack frame values for the current step
  sreg_cnt_t  sreg_total;
  imm12_t     total_adj;
  imm12_t     cur_offset;
  reg_idx_t   cur_sreg;
  step_t      step;

  zcmp_decoder #(
    .EMBEDDED (EMBEDDED)
  ) u_decoder (
    .instr_i       (instr_i),
    .valid_i       (valid_i),
    .halt_i        (halt_i),
    .kill_i        (kill_i),
    .seq_instr_o   (seq_instr),
    .valid_o       (valid_o),
    .seq_pushpop_o (seq_pushpop_o)
  );

  zcmp_stack_calc u_stack_calc (
    .instr_i      (instr_i),
    .seq_instr_i  (seq_instr),
    .step_i       (step),
    .sreg_total_o (sreg_total),
    .total_adj_o  (total_adj),
    .cur_offset_o (cur_offset),
    .cur_sreg_o   (cur_sreg)
  );

  zcmp_seq_fsm u_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_i      (instr_i),
    .seq_instr_i  (seq_instr),
    .valid_i      (valid_o),
    .ready_i      (ready_i),
    .halt_i       (halt_i),
    .kill_i       (kill_i),
    .sreg_total_i (sreg_total),
    .total_adj_i  (total_adj),
    .cur_offset_i (cur_offset),
    .cur_sreg_i   (cur_sreg),
    .step_o       (step),
    .instr_o      (instr_o),
    .ready_o      (ready_o),
    .seq_first_o  (seq_first_o),
    .seq_last_o   (seq_last_o)
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  // Free-running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

/* tb_zcmp_sequencer.sv */
`default_nettype none

module tb_zcmp_sequencer;
  import rv_isa_pkg::*;
  import zcmp_seq_pkg::*;

  // About 40 sequences of at most 17 cycles each, with wide margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic     clk;
  logic     rst_n;
  cinstr_t  instr_i;
  logic     valid_i;
  logic     ready_i;
  logic     halt_i;
  logic     kill_i;
  instr32_t instr_o;
  logic     valid_o;
  logic     ready_o;
  logic     seq_first_o;
  logic     seq_last_o;
  logic     seq_pushpop_o;

  integer seed;
  int     error_count;
  int     check_count;
  int     cycle_count;

  tb_clk_gen #(
    .PERIOD (40)
  ) u_clk_gen (
    .clk_o (clk)
  );

  zcmp_sequencer #(
    .EMBEDDED (1'b0)
  ) UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_i       (instr_i),
    .valid_i       (valid_i),
    .ready_i       (ready_i),
    .halt_i        (halt_i),
    .kill_i        (kill_i),
    .instr_o       (instr_o),
    .valid_o       (valid_o),
    .ready_o       (ready_o),
    .seq_first_o   (seq_first_o),
    .seq_last_o    (seq_last_o),
    .seq_pushpop_o (seq_pushpop_o)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // s0/s1 are x8/x9, s2 upward start at x18
  function automatic reg_idx_t s_reg(int n);
    if (n < 2) begin
      return reg_idx_t'(8 + n);
    end
    return reg_idx_t'(16 + n);
  endfunction

  // lw rd, off(sp)
  function automatic instr32_t enc_load(reg_idx_t rd, int off);
    logic [11:0] imm;
    imm = 12'(off);
    return {imm, 5'd2, 3'b010, rd, 7'b0000011};
  endfunction

  // sw rs2, off(sp), immediate split around the register fields
  function automatic instr32_t enc_store(reg_idx_t rs2, int off);
    logic [11:0] imm;
    imm = 12'(off);
    return {imm[11:5], rs2, 5'd2, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr32_t enc_addi(reg_idx_t rd, reg_idx_t rs1, int val);
    logic [11:0] imm;
    imm = 12'(val);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic int n_sreg(logic [3:0] rlist);
    int r;
    r = int'(rlist);
    return (r == 15) ? 12 : r - 4;
  endfunction

  // s-registers plus ra rounded to 16, then spimm blocks of 16
  function automatic int frame_bytes(logic [3:0] rlist, logic [1:0] spimm);
    int base;
    base = 4 * n_sreg(rlist) + 4;
    return ((base + 15) / 16) * 16 + 16 * int'(spimm);
  endfunction

  function automatic int seq_len(seq_instr_e kind, logic [3:0] rlist);
    case (kind)
      SEQ_POPRET:  return n_sreg(rlist) + 3;
      SEQ_POPRETZ: return n_sreg(rlist) + 4;
      default:     return n_sreg(rlist) + 2;
    endcase
  endfunction

  // Word k of a push or pop sequence
  function automatic instr32_t expected_word(seq_instr_e kind, logic [3:0] rlist,
                                             logic [1:0] spimm, int k);
    instr32_t w;
    int       n;
    int       frame;
    int       off;
    logic     load;
    n     = n_sreg(rlist);
    frame = frame_bytes(rlist, spimm);
    load  = (kind != SEQ_PUSH);
    off   = load ? frame - 4 * (k + 1) : -4 * (k + 1);
    if (k < n) begin
      w = load ? enc_load(s_reg(n - 1 - k), off) : enc_store(s_reg(n - 1 - k), off);
    end else if (k == n) begin
      w = load ? enc_load(5'd1, off) : enc_store(5'd1, off);
    end else if (k == n + 1) begin
      w = enc_addi(5'd2, 5'd2, load ? frame : -frame);
    end else if ((k == n + 2) && (kind == SEQ_POPRETZ)) begin
      w = enc_addi(5'd10, 5'd0, 0);
    end else begin
      // jalr x0, 0(ra)
      w = {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111};
    end
    return w;
  endfunction

  // C2, funct3 101, bits 12:10 and 9:8 select the operation
  function automatic cinstr_t enc_stack(seq_instr_e kind, logic [3:0] rlist,
                                        logic [1:0] spimm);
    logic [2:0] f;
    logic [1:0] sub;
    f   = ((kind == SEQ_PUSH) || (kind == SEQ_POP)) ? 3'b110 : 3'b111;
    sub = ((kind == SEQ_PUSH) || (kind == SEQ_POPRETZ)) ? 2'b00 : 2'b10;
    return {3'b101, f, sub, rlist, spimm, 2'b10};
  endfunction

  function automatic cinstr_t enc_dmove(logic to_s, logic [2:0] r1s, logic [2:0] r2s);
    return {3'b101, 3'b011, r1s, to_s ? 2'b01 : 2'b11, r2s, 2'b10};
  endfunction

  function automatic logic [3:0] random_rlist();
    logic [31:0] rnd;
    rnd = $random(seed);
    return 4'(4 + (rnd % 32'd12));
  endfunction

  function automatic logic [1:0] random_spimm();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[1:0];
  endfunction

  ////////////////////////////////////////
  // Compare and timing helpers
  ////////////////////////////////////////

  task automatic check_word(string name, instr32_t got, instr32_t exp);
    check_count++;
    if (got !== exp) begin
      $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
      error_count++;
    end
  endtask

  // Inputs change just after the rising edge
  task automatic step_clock();
    @(posedge clk);
    #2;
  endtask

  // Outputs are read mid-cycle, once a word is offered
  task automatic wait_word();
    @(negedge clk);
    while (!valid_o) begin
      @(negedge clk);
    end
  endtask

  task automatic end_sequence();
    valid_i = 1'b0;
    instr_i = '0;
    step_clock();
  endtask

  task automatic check_stack_word(seq_instr_e kind, logic [3:0] rlist,
                                  logic [1:0] spimm, int k);
    int len;
    len = seq_len(kind, rlist);
    wait_word();
    check_word("instr_o", instr_o, expected_word(kind, rlist, spimm, k));
    check_flag("seq_first_o", seq_first_o, k == 0);
    check_flag("seq_last_o", seq_last_o, k == len - 1);
    check_flag("ready_o", ready_o, k == len - 1);
    check_flag("seq_pushpop_o", seq_pushpop_o, 1'b1);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic run_stack(seq_instr_e kind, logic [3:0] rlist, logic [1:0] spimm);
    int len;
    len     = seq_len(kind, rlist);
    instr_i = enc_stack(kind, rlist, spimm);
    valid_i = 1'b1;
    ready_i = 1'b1;
    for (int k = 0; k < len; k++) begin
      check_stack_word(kind, rlist, spimm, k);
      step_clock();
    end
    end_sequence();
  endtask

  task automatic run_random(seq_instr_e kind, int count);
    logic [3:0] rlist;
    logic [1:0] spimm;
    for (int i = 0; i < count; i++) begin
      rlist = random_rlist();
      spimm = random_spimm();
      run_stack(kind, rlist, spimm);
    end
  endtask

  task automatic test_push();
    // ra only, then the full list
    run_stack(SEQ_PUSH, 4'd4, 2'd0);
    run_stack(SEQ_PUSH, 4'd15, 2'd3);
    run_random(SEQ_PUSH, 8);
  endtask

  task automatic test_pops();
    run_stack(SEQ_POP, 4'd15, 2'd2);
    run_random(SEQ_POP, 5);
    run_stack(SEQ_POPRET, 4'd4, 2'd1);
    run_random(SEQ_POPRET, 5);
    run_stack(SEQ_POPRETZ, 4'd15, 2'd3);
    run_random(SEQ_POPRETZ, 5);
  endtask

  task automatic run_dmove(logic to_s, logic [2:0] r1s, logic [2:0] r2s);
    instr32_t w0;
    instr32_t w1;
    if (to_s) begin
      w0 = enc_addi(s_reg(int'(r1s)), 5'd10, 0);
      w1 = enc_addi(s_reg(int'(r2s)), 5'd11, 0);
    end else begin
      w0 = enc_addi(5'd10, s_reg(int'(r1s)), 0);
      w1 = enc_addi(5'd11, s_reg(int'(r2s)), 0);
    end
    instr_i = enc_dmove(to_s, r1s, r2s);
    valid_i = 1'b1;
    ready_i = 1'b1;
    wait_word();
    check_word("instr_o", instr_o, w0);
    check_flag("seq_first_o", seq_first_o, 1'b1);
    check_flag("seq_last_o", seq_last_o, 1'b0);
    check_flag("ready_o", ready_o, 1'b0);
    check_flag("seq_pushpop_o", seq_pushpop_o, 1'b0);
    step_clock();
    wait_word();
    check_word("instr_o", instr_o, w1);
    check_flag("seq_first_o", seq_first_o, 1'b0);
    check_flag("seq_last_o", seq_last_o, 1'b1);
    check_flag("ready_o", ready_o, 1'b1);
    step_clock();
    end_sequence();
  endtask

  task automatic test_dmoves();
    run_dmove(1'b1, 3'd0, 3'd1);
    run_dmove(1'b0, 3'd1, 3'd0);
    run_dmove(1'b1, 3'd2, 3'd7);
    run_dmove(1'b0, 3'd5, 3'd3);
  endtask

  // Illegal word must not be offered and must be dropped at once
  task automatic check_rejected(cinstr_t word);
    instr_i = word;
    valid_i = 1'b1;
    ready_i = 1'b1;
    @(negedge clk);
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("ready_o", ready_o, 1'b1);
    step_clock();
    end_sequence();
  endtask

  task automatic test_illegal();
    cinstr_t bad;
    for (int r = 0; r < 4; r++) begin
      check_rejected(enc_stack(SEQ_PUSH, 4'(r), 2'd0));
    end
    check_rejected(enc_dmove(1'b1, 3'd3, 3'd3));
    check_rejected(enc_dmove(1'b0, 3'd6, 3'd6));
    // Same fields in quadrant C1
    bad      = enc_stack(SEQ_PUSH, 4'd7, 2'd0);
    bad[1:0] = 2'b01;
    check_rejected(bad);
  endtask

  // Push with 4 s-registers, stalled at word 2 and halted at word 4
  task automatic test_stall();
    int len;
    len     = seq_len(SEQ_PUSH, 4'd8);
    instr_i = enc_stack(SEQ_PUSH, 4'd8, 2'd1);
    valid_i = 1'b1;
    ready_i = 1'b1;
    for (int k = 0; k < len; k++) begin
      if (k == 2) begin
        ready_i = 1'b0;
        repeat (3) begin
          @(negedge clk);
          check_flag("valid_o", valid_o, 1'b1);
          check_word("instr_o", instr_o, expected_word(SEQ_PUSH, 4'd8, 2'd1, k));
          check_flag("ready_o", ready_o, 1'b0);
          step_clock();
        end
        ready_i = 1'b1;
      end
      if (k == 4) begin
        halt_i = 1'b1;
        repeat (2) begin
          @(negedge clk);
          check_flag("valid_o", valid_o, 1'b0);
          check_flag("ready_o", ready_o, 1'b0);
          step_clock();
        end
        halt_i = 1'b0;
      end
      check_stack_word(SEQ_PUSH, 4'd8, 2'd1, k);
      step_clock();
    end
    end_sequence();
  endtask

  task automatic test_kill();
    instr_i = enc_stack(SEQ_POP, 4'd10, 2'd2);
    valid_i = 1'b1;
    ready_i = 1'b1;
    for (int k = 0; k < 2; k++) begin
      check_stack_word(SEQ_POP, 4'd10, 2'd2, k);
      step_clock();
    end
    kill_i = 1'b1;
    @(negedge clk);
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("ready_o", ready_o, 1'b1);
    step_clock();
    kill_i = 1'b0;
    // Fresh push must start from the top of the frame
    run_stack(SEQ_PUSH, 4'd6, 2'd0);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    seed        = 89;
    error_count = 0;
    check_count = 0;
    rst_n       = 1'b0;
    instr_i     = '0;
    valid_i     = 1'b0;
    ready_i     = 1'b0;
    halt_i      = 1'b0;
    kill_i      = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Idle after reset
    @(negedge clk);
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("ready_o", ready_o, 1'b1);
    check_flag("seq_first_o", seq_first_o, 1'b1);
    step_clock();
    test_push();
    test_pops();
    test_dmoves();
    test_illegal();
    test_stall();
    test_kill();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
             TIMEOUT_CYCLES, error_count);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* zcmp_sequencer.f */
rv_isa_pkg.sv
zcmp_seq_pkg.sv
zcmp_decoder.sv
zcmp_stack_calc.sv
zcmp_seq_fsm.sv
zcmp_sequencer.sv
tb_clk_gen.sv
tb_zcmp_sequencer.sv

/* run.sh */
#!/bin/sh
# Build and run the Zcmp sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_zcmp_sequencer
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f zcmp_sequencer.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
exit 1
